// File: flist.f
+incdir+include
hdl/box_pkg.sv
hdl/apb_regs.sv
hdl/frame_fsm.sv
hdl/scan_counter.sv
hdl/line_buffer.sv
hdl/window_sum.sv
hdl/box_filter_top.sv
testbench/clk_gen.sv
testbench/tb_box_filter.sv

// File: hdl/apb_regs.sv
`include "box_defines.svh"

module apb_regs
  import box_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        i_psel,
  input  logic        i_penable,
  input  logic        i_pwrite,
  input  logic [3:0]  i_paddr,
  input  logic [31:0] i_pwdata,
  output logic [31:0] o_prdata,
  output logic        o_pready,
  output logic        o_pslverr,
  output logic        o_start,
  output coord_t      o_size,
  input  logic        i_busy,
  input  logic        i_done,
  input  logic        i_win_valid
);

  logic        wr_en;
  logic        size_ok;
  logic [6:0]  size_n;
  logic [15:0] win_count;
  coord_t      size_m1;

  assign wr_en   = i_psel && i_penable && i_pwrite;
  assign size_ok = (i_pwdata >= 32'd5) && (i_pwdata <= `BOX_MAX_WIDTH);
  assign size_n  = {1'b0, size_m1} + 7'd1;  // N = 64 needs the seventh bit

  assign o_pready  = 1'b1;
  assign o_pslverr = wr_en && (i_paddr == `BOX_ADDR_SIZE) && !size_ok;
  assign o_start   = wr_en && (i_paddr == `BOX_ADDR_CTRL) && i_pwdata[0] && !i_busy;
  assign o_size    = size_m1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      size_m1   <= coord_t'(7);  // N = 8
      win_count <= '0;
    end else begin
      if (wr_en && (i_paddr == `BOX_ADDR_SIZE) && size_ok) begin
        size_m1 <= coord_t'(i_pwdata - 32'd1);
      end
      if (o_start) begin
        win_count <= '0;
      end else if (i_win_valid) begin
        win_count <= win_count + 16'd1;
      end
    end
  end

  always_comb begin
    case (i_paddr)
      `BOX_ADDR_SIZE:   o_prdata = {25'd0, size_n};
      `BOX_ADDR_STATUS: o_prdata = {30'd0, i_done, i_busy};
      `BOX_ADDR_COUNT:  o_prdata = {16'd0, win_count};
      default:          o_prdata = '0;  // CTRL reads back as zero
    endcase
  end

  // the bus master must hold psel through the access phase
  a_penable_with_psel: assert property (@(posedge clk) disable iff (!rst_n)
    i_penable |-> i_psel);

endmodule

// File: hdl/box_filter_top.sv
module box_filter_top
  import box_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        i_psel,
  input  logic        i_penable,
  input  logic        i_pwrite,
  input  logic [3:0]  i_paddr,
  input  logic [31:0] i_pwdata,
  output logic [31:0] o_prdata,
  output logic        o_pready,
  output logic        o_pslverr,
  input  logic        i_pix_valid,
  input  pix_t        i_pix,
  output logic        o_pix_ready,
  output logic        o_win_valid,
  output winsum_t     o_win_sum,
  output pix_t        o_win_center
);

  logic   start;
  logic   busy;
  logic   done;
  logic   accept;
  logic   flush;
  logic   flush_done;
  logic   last_pix;
  logic   col_valid;
  coord_t size_m1;
  coord_t scan_col;
  coord_t scan_row;
  coord_t lb_col;
  coord_t lb_row;
  pix_t   p0;
  pix_t   p1;
  pix_t   p2;
  pix_t   p3;
  pix_t   p4;

  apb_regs apb_regs_i (
    .clk(clk), .rst_n(rst_n),
    .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
    .i_paddr(i_paddr), .i_pwdata(i_pwdata), .o_prdata(o_prdata),
    .o_pready(o_pready), .o_pslverr(o_pslverr), .o_start(start), .o_size(size_m1),
    .i_busy(busy), .i_done(done), .i_win_valid(o_win_valid)
  );

  frame_fsm frame_fsm_i (
    .clk(clk), .rst_n(rst_n), .i_start(start), .i_pix_valid(i_pix_valid),
    .i_last_pix(last_pix), .i_flush_done(flush_done), .o_accept(accept),
    .o_pix_ready(o_pix_ready), .o_busy(busy), .o_done(done), .o_flush(flush)
  );

  scan_counter scan_counter_i (
    .clk(clk), .rst_n(rst_n), .i_start(start), .i_accept(accept), .i_flush(flush),
    .i_size_m1(size_m1), .o_col(scan_col), .o_row(scan_row),
    .o_last_pix(last_pix), .o_flush_done(flush_done)
  );

  line_buffer line_buffer_i (
    .clk(clk), .rst_n(rst_n), .i_accept(accept), .i_pix(i_pix),
    .i_col(scan_col), .i_row(scan_row), .o_col_valid(col_valid),
    .o_p0(p0), .o_p1(p1), .o_p2(p2), .o_p3(p3), .o_p4(p4),
    .o_col(lb_col), .o_row(lb_row)
  );

  window_sum window_sum_i (
    .clk(clk), .rst_n(rst_n), .i_col_valid(col_valid),
    .i_p0(p0), .i_p1(p1), .i_p2(p2), .i_p3(p3), .i_p4(p4),
    .i_col(lb_col), .i_row(lb_row), .o_win_valid(o_win_valid),
    .o_win_sum(o_win_sum), .o_win_center(o_win_center)
  );

endmodule

// File: hdl/box_pkg.sv
`include "box_defines.svh"

package box_pkg;

  typedef logic [7:0] pix_t;      // greyscale pixel
  typedef logic [10:0] colsum_t;  // five pixels of one column
  typedef logic [12:0] winsum_t;  // all 25 pixels, at most 6375

  typedef logic [`BOX_COORD_W-1:0] coord_t;

  typedef enum logic [1:0] {
    S_IDLE,
    S_RUN,
    S_FLUSH,
    S_DONE
  } frame_state_t;

endpackage

// File: hdl/frame_fsm.sv
module frame_fsm
  import box_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic i_start,
  input  logic i_pix_valid,
  input  logic i_last_pix,
  input  logic i_flush_done,
  output logic o_accept,
  output logic o_pix_ready,
  output logic o_busy,
  output logic o_done,
  output logic o_flush
);

  frame_state_t state;
  frame_state_t state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE, S_DONE: begin
        if (i_start) state_nxt = S_RUN;
      end
      S_RUN: begin
        if (o_accept && i_last_pix) state_nxt = S_FLUSH;
      end
      S_FLUSH: begin
        if (i_flush_done) state_nxt = S_DONE;  // pipeline has drained
      end
      default: state_nxt = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign o_pix_ready = (state == S_RUN);
  assign o_accept    = o_pix_ready && i_pix_valid;
  assign o_flush     = (state == S_FLUSH);
  assign o_busy      = (state == S_RUN) || (state == S_FLUSH);
  assign o_done      = (state == S_DONE);

  // five drain cycles cover the window pipeline
  a_flush_five_cycles: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(o_done) |-> $past(o_flush, 5) && !$past(o_flush, 6));

endmodule

// File: hdl/line_buffer.sv
`include "box_defines.svh"

module line_buffer
  import box_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   i_accept,
  input  pix_t   i_pix,
  input  coord_t i_col,
  input  coord_t i_row,
  output logic   o_col_valid,
  output pix_t   o_p0,
  output pix_t   o_p1,
  output pix_t   o_p2,
  output pix_t   o_p3,
  output pix_t   o_p4,
  output coord_t o_col,
  output coord_t o_row
);

  // row r lives in bank r mod 4, so the bank about to be written still holds row r-4
  pix_t mem [4][`BOX_MAX_WIDTH];

  logic [1:0] bank;
  pix_t       rd0;
  pix_t       rd1;
  pix_t       rd2;
  pix_t       rd3;

  assign bank = i_row[1:0];

  assign rd0 = mem[bank][i_col];          // row r-4
  assign rd1 = mem[bank + 2'd1][i_col];   // row r-3
  assign rd2 = mem[bank + 2'd2][i_col];
  assign rd3 = mem[bank + 2'd3][i_col];   // row r-1

  always_ff @(posedge clk) begin
    if (i_accept) begin
      mem[bank][i_col] <= i_pix;  // read above sees the old row first
      o_p0  <= rd0;
      o_p1  <= rd1;
      o_p2  <= rd2;
      o_p3  <= rd3;
      o_p4  <= i_pix;
      o_col <= i_col;
      o_row <= i_row;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_col_valid <= 1'b0;
    end else begin
      o_col_valid <= i_accept;
    end
  end

endmodule

// File: hdl/scan_counter.sv
module scan_counter
  import box_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   i_start,
  input  logic   i_accept,
  input  logic   i_flush,
  input  coord_t i_size_m1,
  output coord_t o_col,
  output coord_t o_row,
  output logic   o_last_pix,
  output logic   o_flush_done
);

  coord_t col;
  coord_t row;
  logic   col_end;

  assign col_end      = (col == i_size_m1);
  assign o_last_pix   = col_end && (row == i_size_m1);
  assign o_flush_done = i_flush && (col == coord_t'(4));  // five drain cycles from zero
  assign o_col        = col;
  assign o_row        = row;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col <= '0;
      row <= '0;
    end else if (i_start) begin
      col <= '0;
      row <= '0;
    end else if (i_accept) begin
      if (col_end) begin
        col <= '0;
        row <= row + coord_t'(1);
      end else begin
        col <= col + coord_t'(1);
      end
    end else if (i_flush && !o_flush_done) begin
      // the last pixel left col at zero, so it doubles as the drain timer
      col <= col + coord_t'(1);
    end
  end

endmodule

// File: hdl/window_sum.sv
module window_sum
  import box_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    i_col_valid,
  input  pix_t    i_p0,
  input  pix_t    i_p1,
  input  pix_t    i_p2,
  input  pix_t    i_p3,
  input  pix_t    i_p4,
  input  coord_t  i_col,
  input  coord_t  i_row,
  output logic    o_win_valid,
  output winsum_t o_win_sum,
  output pix_t    o_win_center
);

  localparam winsum_t WIN_MAX = 13'd6375;

  logic       valid1;
  logic       valid2;
  logic       valid3;
  logic       win_ok3;
  logic [8:0] s01;
  logic [8:0] s23;
  pix_t       p4_d1;
  pix_t       ctr_d1;
  pix_t       ctr_d2;
  pix_t       ctr_h0;
  pix_t       ctr_h1;
  pix_t       ctr_3;
  coord_t     col1;
  coord_t     row1;
  coord_t     col2;
  coord_t     row2;
  colsum_t    colsum2;
  colsum_t    hist [5];
  winsum_t    run_sum;
  winsum_t    run_sub;

  // first tree level pairs the upper four rows
  always_ff @(posedge clk) begin
    s01    <= 9'(i_p0) + 9'(i_p1);
    s23    <= 9'(i_p2) + 9'(i_p3);
    p4_d1  <= i_p4;
    ctr_d1 <= i_p2;
    col1   <= i_col;
    row1   <= i_row;
  end

  always_ff @(posedge clk) begin
    colsum2 <= colsum_t'(s01) + colsum_t'(s23) + colsum_t'(p4_d1);
    ctr_d2  <= ctr_d1;
    col2    <= col1;
    row2    <= row1;
  end

  // hist[4] holds column c-5 which drops out of the window
  assign run_sub = (col2 >= coord_t'(5)) ? winsum_t'(hist[4]) : '0;

  always_ff @(posedge clk) begin
    if (valid2) begin
      hist[0] <= colsum2;
      for (int k = 4; k > 0; k--) begin
        hist[k] <= hist[k-1];
      end
      if (col2 == '0) begin
        run_sum <= winsum_t'(colsum2);  // new row starts a fresh sum
      end else begin
        run_sum <= run_sum + winsum_t'(colsum2) - run_sub;
      end
      ctr_h0  <= ctr_d2;
      ctr_h1  <= ctr_h0;
      ctr_3   <= ctr_h1;  // centre sits two columns back
      win_ok3 <= (row2 >= coord_t'(4)) && (col2 >= coord_t'(4));
    end
  end

  always_ff @(posedge clk) begin
    if (valid3) begin
      o_win_sum    <= run_sum;
      o_win_center <= ctr_3;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid1      <= 1'b0;
      valid2      <= 1'b0;
      valid3      <= 1'b0;
      o_win_valid <= 1'b0;
    end else begin
      valid1      <= i_col_valid;
      valid2      <= valid1;
      valid3      <= valid2;
      o_win_valid <= valid3 && win_ok3;
    end
  end

  a_sum_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    valid3 |-> run_sum <= WIN_MAX);

endmodule

// File: include/box_defines.svh
`ifndef BOX_DEFINES_SVH
`define BOX_DEFINES_SVH

// depth of one row memory, also the largest legal N
`define BOX_MAX_WIDTH 64

// width of column and row indices
`define BOX_COORD_W 6

// APB register map
`define BOX_ADDR_CTRL   4'h0
`define BOX_ADDR_SIZE   4'h4
`define BOX_ADDR_STATUS 4'h8
`define BOX_ADDR_COUNT  4'hC

`endif

// File: run.sh
#!/bin/sh
# build and run the box filter testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ps \
  --top-module tb_box_filter -f flist.f -o sim_box

./obj_dir/sim_box | tee sim.log

if grep -q "All checks passed" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// File: testbench/box_input.txt
// per frame: size N, then N rows of N pixels, then (N-4)^2 pairs of window sum and centre
// frame 0, 8x8, pixel = 16*row + col
08
00 01 02 03 04 05 06 07
10 11 12 13 14 15 16 17
20 21 22 23 24 25 26 27
30 31 32 33 34 35 36 37
40 41 42 43 44 45 46 47
50 51 52 53 54 55 56 57
60 61 62 63 64 65 66 67
70 71 72 73 74 75 76 77
0352 22 036b 23 0384 24 039d 25
04e2 32 04fb 33 0514 34 052d 35
0672 42 068b 43 06a4 44 06bd 45
0802 52 081b 53 0834 54 084d 55
// frame 1, 6x6, pixel = 240 - 16*row - col
06
f0 ef ee ed ec eb
e0 df de dd dc db
d0 cf ce cd cc cb
c0 bf be bd bc bb
b0 af ae ad ac ab
a0 9f 9e 9d 9c 9b
141e ce 1405 cd 128e be 1275 bd

// File: testbench/clk_gen.sv
module clk_gen (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #20 o_clk = ~o_clk;
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (10) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;  // released on a falling edge like all other inputs
  end

endmodule

// File: testbench/tb_box_filter.sv
`include "box_defines.svh"

module tb_box_filter
  import box_pkg::*;
;

  localparam int NUM_FRAMES = 2;

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        pix_valid;
  pix_t        pix;
  logic        pix_ready;
  logic        win_valid;
  winsum_t     win_sum;
  pix_t        win_center;

  logic [15:0] stim [256];  // frame size, pixels, then expected sum and centre pairs
  logic [15:0] exp_sum [$];
  logic [15:0] exp_ctr [$];
  logic [15:0] want_sum;
  logic [15:0] want_ctr;
  logic [15:0] lfsr;
  int          errors;
  int          beats;
  int          cycles;
  int          limit;

  clk_gen clk_gen_i (.o_clk(clk), .o_rst_n(rst_n));

  box_filter_top dut_i (
    .clk(clk), .rst_n(rst_n),
    .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite), .i_paddr(paddr),
    .i_pwdata(pwdata), .o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr),
    .i_pix_valid(pix_valid), .i_pix(pix), .o_pix_ready(pix_ready),
    .o_win_valid(win_valid), .o_win_sum(win_sum), .o_win_center(win_center)
  );

  function automatic logic [15:0] word_at(input int addr);
    return stim[addr[7:0]];
  endfunction

  // taps 16, 14, 13, 11
  function automatic logic [15:0] next_lfsr(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic int pixel_total();
    int pos;
    int n;
    int total;
    pos = 0;
    total = 0;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      n = int'(word_at(pos));
      total += n * n;
      pos += 1 + n * n + 2 * (n - 4) * (n - 4);
    end
    return total;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("error at time %0t: %s expected 0x%0h, actual 0x%0h",
               $time, name, expected, actual);
      $display("Checks failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    err     = pslverr;  // access phase held across one rising edge
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    check_value("o_pready", 32'd1, 32'(pready));
    data    = prdata;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic queue_windows(input int pos, input int count);
    for (int k = 0; k < count; k++) begin
      exp_sum.push_back(word_at(pos + 2 * k));
      exp_ctr.push_back(word_at(pos + 2 * k + 1));
    end
  endtask

  task automatic stream_frame(input int pos, input int n, input bit use_gaps);
    int          idx;
    logic        gap;
    logic [15:0] w;
    idx = 0;
    while (idx < n * n) begin
      @(negedge clk);
      gap = 1'b0;
      if (use_gaps) begin
        lfsr = next_lfsr(lfsr);
        gap  = lfsr[0];
      end
      if (gap) begin
        pix_valid = 1'b0;
      end else begin
        w         = word_at(pos + idx);
        pix_valid = 1'b1;
        pix       = w[7:0];
        if (pix_ready) idx++;  // ready only moves on a rising edge
      end
    end
    @(negedge clk);
    pix_valid = 1'b0;
  endtask

  task automatic wait_for_done();
    logic [31:0] status;
    status = '0;
    while (status[1] == 1'b0) begin
      read_reg(`BOX_ADDR_STATUS, status);
    end
  endtask

  // results are registered, so the falling edge sees them settled
  always @(negedge clk) begin
    if (rst_n && win_valid) begin
      if (exp_sum.size() == 0) begin
        $display("a window came out after all expected windows of the frame were seen");
        $display("Checks failed");
        $fatal(1, "unexpected window");
      end else begin
        want_sum = exp_sum.pop_front();
        want_ctr = exp_ctr.pop_front();
        check_value("o_win_sum", 32'(want_sum), 32'(win_sum));
        check_value("o_win_center", 32'(want_ctr), 32'(win_center));
        beats++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= limit) begin
      $display("the run did not finish within %0d cycles", limit);
      $display("Checks failed");
      $fatal(1, "timeout");
    end
  end

  initial begin
    logic [31:0] rdata;
    logic        err;
    int          pos;
    int          n;
    int          wins;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    pix_valid = 1'b0;
    pix       = '0;
    lfsr      = 16'd23;
    errors    = 0;
    beats     = 0;
    cycles    = 0;
    $readmemh("testbench/box_input.txt", stim);
    limit = 4 * pixel_total() + 400;

    @(posedge rst_n);
    @(negedge clk);
    check_value("o_pix_ready", 32'd0, 32'(pix_ready));
    check_value("o_win_valid", 32'd0, 32'(win_valid));
    read_reg(`BOX_ADDR_STATUS, rdata);
    check_value("STATUS", 32'd0, rdata);
    read_reg(`BOX_ADDR_COUNT, rdata);
    check_value("COUNT", 32'd0, rdata);
    repeat (3) begin
      @(negedge clk);
      check_value("o_pix_ready", 32'd0, 32'(pix_ready));  // no frame started yet
      pix_valid = 1'b1;
      pix       = 8'hA5;
    end
    @(negedge clk);
    check_value("o_pix_ready", 32'd0, 32'(pix_ready));
    pix_valid = 1'b0;

    write_reg(`BOX_ADDR_SIZE, 32'd8, err);
    check_value("o_pslverr", 32'd0, 32'(err));
    read_reg(`BOX_ADDR_SIZE, rdata);
    check_value("SIZE", 32'd8, rdata);
    write_reg(`BOX_ADDR_SIZE, 32'd3, err);
    check_value("o_pslverr", 32'd1, 32'(err));
    write_reg(`BOX_ADDR_SIZE, 32'd65, err);
    check_value("o_pslverr", 32'd1, 32'(err));
    read_reg(`BOX_ADDR_SIZE, rdata);
    check_value("SIZE", 32'd8, rdata);

    pos = 0;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      n    = int'(word_at(pos));
      wins = (n - 4) * (n - 4);
      write_reg(`BOX_ADDR_SIZE, n, err);
      check_value("o_pslverr", 32'd0, 32'(err));
      queue_windows(pos + 1 + n * n, wins);
      beats = 0;
      write_reg(`BOX_ADDR_CTRL, 32'd1, err);
      stream_frame(pos + 1, n, f != 0);  // second frame gets random valid gaps
      wait_for_done();
      @(negedge clk);
      check_value("window beats", wins, beats);
      read_reg(`BOX_ADDR_STATUS, rdata);
      check_value("STATUS", 32'd2, rdata);
      read_reg(`BOX_ADDR_COUNT, rdata);
      check_value("COUNT", wins, rdata);
      pos += 1 + n * n + 2 * wins;
    end

    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
